// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_ifetch
FILELIST = vlog.f
OBJ_DIR  = obj_dir
PASS_MSG = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== axi_pkg.sv ====
package axi_pkg;

    // channel field widths
    localparam int AXI_ADDR_W  = 64;
    localparam int AXI_DATA_W  = 64;
    localparam int AXI_ID_W    = 4;
    localparam int AXI_LEN_W   = 8;
    localparam int AXI_SIZE_W  = 3;
    localparam int AXI_BURST_W = 2;
    localparam int AXI_PROT_W  = 3;
    localparam int AXI_CACHE_W = 4;
    localparam int AXI_RESP_W  = 2;
    localparam int AXI_USER_W  = 1;

    localparam logic [AXI_BURST_W-1:0] AXI_BURST_INCR = 2'b01;

    // bit0 privileged, bit1 non-secure, bit2 instruction
    // all clear means unprivileged secure data access
    localparam logic [AXI_PROT_W-1:0] AXI_PROT_DEFAULT = 3'b000;

    localparam logic [AXI_CACHE_W-1:0] AXI_CACHE_NORMAL_NC_NB = 4'b0010;

    localparam logic [AXI_RESP_W-1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [AXI_RESP_W-1:0] AXI_RESP_SLVERR = 2'b10;

    // fixed sideband values, never leave the design
    localparam logic [AXI_ID_W-1:0]   AXI_ID_FETCH       = '0;
    localparam logic [AXI_USER_W-1:0] AXI_USER_DEFAULT   = '0;
    localparam logic [3:0]            AXI_REGION_DEFAULT = 4'h0;

    typedef struct packed {
        logic [AXI_ADDR_W-1:0]  addr;
        logic [AXI_LEN_W-1:0]   len;   // beats minus one
        logic [AXI_SIZE_W-1:0]  size;  // log2 bytes per beat
        logic [AXI_BURST_W-1:0] burst;
        logic [AXI_PROT_W-1:0]  prot;
        logic [AXI_CACHE_W-1:0] cache;
        logic [AXI_ID_W-1:0]    id;
    } axi_ar_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_RESP_W-1:0] resp;
        logic                  last;
        logic [AXI_ID_W-1:0]   id;
    } axi_r_t;

endpackage

// ==== axi_rd_if.sv ====
`timescale 1ns/1ps

interface axi_rd_if;
    import axi_pkg::*;

    // read address group
    logic    arvalid;
    logic    arready;
    axi_ar_t ar;

    // read data group
    logic    rvalid;
    logic    rready;
    axi_r_t  r;

    // requesting side
    modport master (
        output arvalid,
        output ar,
        input  arready,
        input  rvalid,
        input  r,
        output rready
    );

    // responding side
    modport slave (
        input  arvalid,
        input  ar,
        output arready,
        output rvalid,
        output r,
        input  rready
    );

endinterface

// ==== beat_collector.sv ====
`timescale 1ns/1ps

module beat_collector (
    input  logic             clock,
    input  logic             reset,
    axi_rd_if.master         beats,   // R side only
    input  logic             start_i,
    output fetch_pkg::line_t line_o,
    output logic             done_o,
    output logic             err_o
);
    import axi_pkg::*;
    import fetch_pkg::*;

    line_t                 line_q;
    logic [BEAT_IDX_W-1:0] idx_q;    // next slot
    logic                  active_q; // burst in flight
    logic                  done_q;
    logic                  err_q;
    logic                  beat_fire;

    assign beats.rready = active_q;
    assign beat_fire    = beats.rvalid & beats.rready;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            idx_q    <= '0;
            active_q <= 1'b0;
            done_q   <= 1'b0;
            err_q    <= 1'b0;
        end else if (start_i) begin
            idx_q    <= '0;
            active_q <= 1'b1;
            done_q   <= 1'b0;
            err_q    <= 1'b0;    // fresh status per burst
        end else begin
            done_q <= beat_fire & beats.r.last;  // one cycle after the last beat
            if (beat_fire) begin
                idx_q <= idx_q + 1'b1;
                err_q <= err_q | (beats.r.resp != AXI_RESP_OKAY);  // sticky
                if (beats.r.last) begin
                    active_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (beat_fire) begin
            line_q[idx_q] <= beats.r.data;
        end
    end

    assign line_o = line_q;
    assign done_o = done_q;
    assign err_o  = err_q;  // held until the next burst starts

    a_last_pos: assert property (@(posedge clock) disable iff (!reset)
        beat_fire |-> beats.r.last == (idx_q == BEAT_IDX_W'(LINE_BEATS - 1)))
        else $error("rlast not on the final beat of the line");

endmodule

// ==== chan_slice.sv ====
`timescale 1ns/1ps

// one register stage on a valid/ready channel
module chan_slice #(
    parameter type payload_t   = logic,
    parameter bit  EMPTY_READY = 1'b1   // take a new item while empty, even if stalled downstream
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);
    logic     valid_q;
    payload_t data_q;
    logic     load;

    // old item leaves as the new one enters
    assign in_ready_o = out_ready_i | (EMPTY_READY & ~valid_q);
    assign load       = in_valid_i & in_ready_o;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;  // refill or drain
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    // stalled item must wait unchanged at the output
    a_hold: assert property (@(posedge clock) disable iff (!reset)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
        else $error("chan_slice dropped or changed a stalled item");

endmodule

// ==== fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       fetch_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] fetch_addr_i,
    input  logic                       hit_i,
    input  logic                       line_done_i,
    input  logic                       line_err_i,
    output logic                       fill_o,
    output logic                       fetch_ready_o,
    output logic                       fetch_busy_o,
    axi_rd_if.master                   ar
);
    import axi_pkg::*;
    import fetch_pkg::*;

    fetch_state_t state_q;
    fetch_state_t state_d;
    tag_t         miss_tag_q;   // line being fetched
    logic         ar_fire;

    assign ar_fire = ar.arvalid & ar.arready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (fetch_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                state_d = hit_i ? RESPOND : AR_ISSUE;
            end
            AR_ISSUE: begin
                if (ar_fire) begin
                    state_d = R_COLLECT;
                end
            end
            R_COLLECT: begin
                if (line_done_i) begin
                    state_d = RESPOND;  // line buffer written on this edge
                end
            end
            RESPOND: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // address is stable from the requester, latch it once for the AR payload
    always_ff @(posedge clock) begin
        if (state_q == LOOKUP && !hit_i) begin
            miss_tag_q <= fetch_addr_i[XLEN-1:OFFSET_W];
        end
    end

    assign ar.arvalid = (state_q == AR_ISSUE);
    assign ar.ar = '{
        addr:  {miss_tag_q, {OFFSET_W{1'b0}}},  // line aligned
        len:   AXI_LEN_W'(BURST_LEN),
        size:  AXI_SIZE_W'(BURST_SIZE),
        burst: AXI_BURST_INCR,
        prot:  AXI_PROT_DEFAULT,
        cache: AXI_CACHE_NORMAL_NC_NB,
        id:    AXI_ID_FETCH
    };

    // buffer decides keep or drop from the error flag
    assign fill_o        = (state_q == R_COLLECT) && line_done_i;
    assign fetch_ready_o = (state_q == RESPOND);
    assign fetch_busy_o  = (state_q == AR_ISSUE) || (state_q == R_COLLECT);

    a_ar_stable: assert property (@(posedge clock) disable iff (!reset)
        ar.arvalid && !ar.arready |=> ar.arvalid && $stable(ar.ar))
        else $error("arvalid or AR payload changed while arready low");

    a_ready_pulse: assert property (@(posedge clock) disable iff (!reset)
        fetch_ready_o |=> !fetch_ready_o)
        else $error("fetch_ready_o high for two cycles");

    // word served from the buffer unless the fill failed
    a_respond_src: assert property (@(posedge clock) disable iff (!reset)
        state_q == RESPOND |-> hit_i != line_err_i)
        else $error("response without a valid line and without an error");

endmodule

// ==== fetch_pkg.sv ====
package fetch_pkg;

    localparam int INSTR_W    = 32;
    localparam int XLEN       = 64;
    localparam int LINE_BEATS = 4;                      // 64-bit beats per line
    localparam int LINE_BYTES = LINE_BEATS * XLEN / 8;  // 32
    localparam int OFFSET_W   = $clog2(LINE_BYTES);     // 5
    localparam int BEAT_IDX_W = $clog2(LINE_BEATS);     // 2

    // burst shape for a line fill
    localparam int BURST_LEN  = LINE_BEATS - 1;         // axi len field
    localparam int BURST_SIZE = $clog2(XLEN / 8);       // 8 bytes per beat

    // beat 0 sits in the low 64 bits
    typedef logic [LINE_BEATS-1:0][XLEN-1:0] line_t;

    // address bits above the line offset
    typedef logic [XLEN-OFFSET_W-1:0] tag_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,     // one cycle for the tag compare
        AR_ISSUE,   // push the burst request
        R_COLLECT,  // wait for the line to assemble
        RESPOND     // fetch_ready_o pulse
    } fetch_state_t;

endpackage

// ==== ifetch_axi_top.sv ====
`timescale 1ns/1ps

module ifetch_axi_top (
    input  logic                              clock,
    input  logic                              reset,

    // requester
    input  logic                              fetch_valid_i,
    input  logic [fetch_pkg::XLEN-1:0]        fetch_addr_i,
    output logic                              fetch_ready_o,
    output logic [fetch_pkg::INSTR_W-1:0]     fetch_data_o,
    output logic                              fetch_err_o,
    output logic                              fetch_busy_o,

    // axi read address
    output logic                              axi_ar_valid_o,
    input  logic                              axi_ar_ready_i,
    output logic [axi_pkg::AXI_ADDR_W-1:0]    axi_ar_addr_o,
    output logic [axi_pkg::AXI_LEN_W-1:0]     axi_ar_len_o,
    output logic [axi_pkg::AXI_SIZE_W-1:0]    axi_ar_size_o,
    output logic [axi_pkg::AXI_BURST_W-1:0]   axi_ar_burst_o,
    output logic [axi_pkg::AXI_PROT_W-1:0]    axi_ar_prot_o,
    output logic [axi_pkg::AXI_CACHE_W-1:0]   axi_ar_cache_o,
    output logic [axi_pkg::AXI_ID_W-1:0]      axi_ar_id_o,

    // axi read data
    input  logic                              axi_r_valid_i,
    output logic                              axi_r_ready_o,
    input  logic [axi_pkg::AXI_DATA_W-1:0]    axi_r_data_i,
    input  logic [axi_pkg::AXI_RESP_W-1:0]    axi_r_resp_i,
    input  logic                              axi_r_last_i,
    input  logic [axi_pkg::AXI_ID_W-1:0]      axi_r_id_i
);
    import axi_pkg::*;
    import fetch_pkg::*;

    axi_rd_if ctrl_bus ();   // controller and port side of the slices
    axi_rd_if beat_bus ();   // R slice to collector

    axi_ar_t ar_q;
    line_t   line;
    logic    hit;
    logic    fill;
    logic    line_done;
    logic    line_err;

    fetch_ctrl u_ctrl (
        .clock         (clock),
        .reset         (reset),
        .fetch_valid_i (fetch_valid_i),
        .fetch_addr_i  (fetch_addr_i),
        .hit_i         (hit),
        .line_done_i   (line_done),
        .line_err_i    (line_err),
        .fill_o        (fill),
        .fetch_ready_o (fetch_ready_o),
        .fetch_busy_o  (fetch_busy_o),
        .ar            (ctrl_bus.master)
    );

    chan_slice #(.payload_t(axi_ar_t)) u_ar_slice (
        .clock       (clock),
        .reset       (reset),
        .in_valid_i  (ctrl_bus.arvalid),
        .in_ready_o  (ctrl_bus.arready),
        .in_data_i   (ctrl_bus.ar),
        .out_valid_o (axi_ar_valid_o),
        .out_ready_i (axi_ar_ready_i),
        .out_data_o  (ar_q)
    );

    assign axi_ar_addr_o  = ar_q.addr;
    assign axi_ar_len_o   = ar_q.len;
    assign axi_ar_size_o  = ar_q.size;
    assign axi_ar_burst_o = ar_q.burst;
    assign axi_ar_prot_o  = ar_q.prot;
    assign axi_ar_cache_o = ar_q.cache;
    assign axi_ar_id_o    = ar_q.id;

    // R port fields packed into one beat
    assign ctrl_bus.rvalid = axi_r_valid_i;
    assign ctrl_bus.r      = '{data: axi_r_data_i, resp: axi_r_resp_i,
                               last: axi_r_last_i, id: axi_r_id_i};
    assign axi_r_ready_o   = ctrl_bus.rready;

    // rready follows the collector, low outside a burst
    chan_slice #(.payload_t(axi_r_t), .EMPTY_READY(1'b0)) u_r_slice (
        .clock       (clock),
        .reset       (reset),
        .in_valid_i  (ctrl_bus.rvalid),
        .in_ready_o  (ctrl_bus.rready),
        .in_data_i   (ctrl_bus.r),
        .out_valid_o (beat_bus.rvalid),
        .out_ready_i (beat_bus.rready),
        .out_data_o  (beat_bus.r)
    );

    beat_collector u_collect (
        .clock   (clock),
        .reset   (reset),
        .beats   (beat_bus.master),
        .start_i (ctrl_bus.arvalid),   // arms the collector before any beat
        .line_o  (line),
        .done_o  (line_done),
        .err_o   (line_err)
    );

    line_buffer u_line (
        .clock      (clock),
        .reset      (reset),
        .addr_i     (fetch_addr_i),
        .fill_i     (fill),
        .line_i     (line),
        .fill_err_i (line_err),
        .hit_o      (hit),
        .word_o     (fetch_data_o)
    );

    assign fetch_err_o = line_err;   // valid with fetch_ready_o

endmodule

// ==== line_buffer.sv ====
`timescale 1ns/1ps

// single line cache, tag compare and word select
module line_buffer (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [fetch_pkg::XLEN-1:0]    addr_i,
    input  logic                          fill_i,
    input  fetch_pkg::line_t              line_i,
    input  logic                          fill_err_i,
    output logic                          hit_o,
    output logic [fetch_pkg::INSTR_W-1:0] word_o
);
    import fetch_pkg::*;

    line_t                 line_q;
    tag_t                  tag_q;
    logic                  valid_q;
    tag_t                  addr_tag;
    logic [BEAT_IDX_W-1:0] beat_sel;
    logic                  word_sel;   // upper or lower half of the beat
    logic [XLEN-1:0]       beat;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid_q <= 1'b0;
        end else if (fill_i) begin
            valid_q <= ~fill_err_i;   // failed fill drops the old line too
        end
    end

    always_ff @(posedge clock) begin
        if (fill_i) begin
            tag_q  <= addr_i[XLEN-1:OFFSET_W];
            line_q <= line_i;
        end
    end

    assign addr_tag = addr_i[XLEN-1:OFFSET_W];
    assign hit_o    = valid_q && (tag_q == addr_tag);

    // offset splits into beat index and word within the beat
    assign beat_sel = addr_i[OFFSET_W-1 -: BEAT_IDX_W];
    assign word_sel = addr_i[OFFSET_W-BEAT_IDX_W-1];
    assign beat     = line_q[beat_sel];
    assign word_o   = beat[word_sel*INSTR_W +: INSTR_W];

endmodule

// ==== tb_ifetch.sv ====
`timescale 1ns/1ps

module tb_ifetch;

    localparam int NUM_ROWS       = 16;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 64;
    localparam int HIT_EDGES      = 3;   // drive edge, edge into LOOKUP, edge into RESPOND

    typedef struct packed {
        logic [63:0] addr;
        logic        new_ar;   // line not held so one burst expected
        logic        err;      // memory answers this line with SLVERR
    } row_t;

    row_t rows [NUM_ROWS] = '{
        '{64'h0000_0000_8000_0000, 1'b1, 1'b0},  // cold miss
        '{64'h0000_0000_8000_0014, 1'b0, 1'b0},  // upper word of beat 2 in the same line
        '{64'h0000_0000_8000_001c, 1'b0, 1'b0},
        '{64'h0000_0000_8000_0020, 1'b1, 1'b0},  // next line
        '{64'h0000_0000_8000_0000, 1'b1, 1'b0},  // evicted so fetched again
        '{64'h0000_0000_8000_0008, 1'b0, 1'b0},
        '{64'h0000_0012_8000_0008, 1'b1, 1'b0},  // only the high tag bits differ
        '{64'h0000_0000_4000_0040, 1'b1, 1'b1},
        '{64'h0000_0000_4000_0048, 1'b1, 1'b0},  // bad line was not kept
        '{64'h0000_0000_4000_005c, 1'b0, 1'b0},
        '{64'h0000_0000_4000_0060, 1'b1, 1'b1},
        '{64'h0000_0000_4000_0060, 1'b1, 1'b1},  // two failures in a row
        '{64'h0000_0000_4000_0064, 1'b1, 1'b0},
        '{64'h0000_0000_4000_0078, 1'b0, 1'b0},
        '{64'hffff_ffff_ffff_ffe0, 1'b1, 1'b0},  // top of the address space
        '{64'hffff_ffff_ffff_fffc, 1'b0, 1'b0}
    };

    logic        clock       = 1'b0;
    logic        reset       = 1'b0;
    logic        fetch_valid = 1'b0;
    logic [63:0] fetch_addr  = '0;
    logic        fetch_ready;
    logic [31:0] fetch_data;
    logic        fetch_err;
    logic        fetch_busy;

    // AR and R wires at the DUT ports
    logic        ar_valid;
    logic        ar_ready = 1'b0;
    logic [63:0] ar_addr;
    logic [7:0]  ar_len;
    logic [2:0]  ar_size;
    logic [1:0]  ar_burst;
    logic [2:0]  ar_prot;
    logic [3:0]  ar_cache;
    logic [3:0]  ar_id;
    logic        r_valid  = 1'b0;
    logic        r_ready;
    logic [63:0] r_data   = '0;
    logic [1:0]  r_resp   = '0;
    logic        r_last   = 1'b0;
    logic [3:0]  r_id     = '0;   // single id echoed as zero

    // memory model state
    logic [31:0] lfsr       = 32'h4c576688;
    logic        burst_open = 1'b0;
    logic [2:0]  beat_idx   = '0;
    logic [63:0] burst_addr = '0;
    logic [63:0] beat_addr;
    logic        burst_err  = 1'b0;
    int          ar_count   = 0;
    int          last_beat_cycle = 0;
    int          bus_errs   = 0;

    int          cycle       = 0;
    int          row_idx     = 0;
    logic [63:0] cur_addr    = '0;
    logic        cur_err     = 1'b0;
    int          data_errs   = 0;
    int          ar_errs     = 0;
    int          timing_errs = 0;
    int          flag_errs   = 0;

    ifetch_axi_top uut (
        .clock (clock), .reset (reset),
        .fetch_valid_i (fetch_valid), .fetch_addr_i (fetch_addr),
        .fetch_ready_o (fetch_ready), .fetch_data_o (fetch_data),
        .fetch_err_o (fetch_err), .fetch_busy_o (fetch_busy),
        .axi_ar_valid_o (ar_valid), .axi_ar_ready_i (ar_ready), .axi_ar_addr_o (ar_addr),
        .axi_ar_len_o (ar_len), .axi_ar_size_o (ar_size), .axi_ar_burst_o (ar_burst),
        .axi_ar_prot_o (ar_prot), .axi_ar_cache_o (ar_cache), .axi_ar_id_o (ar_id),
        .axi_r_valid_i (r_valid), .axi_r_ready_o (r_ready), .axi_r_data_i (r_data),
        .axi_r_resp_i (r_resp), .axi_r_last_i (r_last), .axi_r_id_i (r_id)
    );

    initial begin
        forever #4 clock = ~clock;   // 8 ns period
    end

    always @(posedge clock) cycle <= cycle + 1;

    // fibonacci with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // every word holds its own address xor a constant
    function automatic logic [31:0] mem_word(input logic [63:0] addr);
        return addr[31:0] ^ 32'ha5a5a5a5;
    endfunction

    task automatic expect_eq(input string name, input logic [63:0] got,
                             input logic [63:0] exp, inout int errs);
        assert (got == exp) else begin
            $display("mismatch at %0t: %s = %0h, expected %0h", $time, name, got, exp);
            errs++;
        end
    endtask

    // AXI slave with random stalls on arready and rvalid
    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            ar_ready   <= 1'b0;
            r_valid    <= 1'b0;
            r_last     <= 1'b0;
            burst_open = 1'b0;
        end else begin
            if (r_valid && r_ready) begin
                if (r_last) begin
                    burst_open      = 1'b0;
                    last_beat_cycle <= cycle + 1;   // count seen after this edge
                end
                beat_idx = beat_idx + 3'd1;
            end
            if (ar_valid && ar_ready) begin
                assert (!burst_open) else begin
                    $display("second AR accepted at %0t while a burst is still open", $time);
                    bus_errs++;
                end
                expect_eq("axi_ar_addr_o", ar_addr, {cur_addr[63:5], 5'b0}, bus_errs);
                expect_eq("axi_ar_len_o", 64'(ar_len), 64'd3, bus_errs);
                expect_eq("axi_ar_size_o", 64'(ar_size), 64'd3, bus_errs);     // 8 bytes
                expect_eq("axi_ar_burst_o", 64'(ar_burst), 64'd1, bus_errs);   // INCR
                expect_eq("axi_ar_prot_o", 64'(ar_prot), 64'd0, bus_errs);
                expect_eq("axi_ar_cache_o", 64'(ar_cache), 64'd2, bus_errs);   // normal nc nb
                expect_eq("axi_ar_id_o", 64'(ar_id), 64'd0, bus_errs);
                burst_open = 1'b1;
                beat_idx   = 3'd0;
                burst_addr = ar_addr;
                burst_err  = cur_err;
                ar_count   = ar_count + 1;
            end
            lfsr = lfsr_step(lfsr);
            ar_ready <= lfsr[0];
            if (!(r_valid && !r_ready)) begin   // a stalled beat stays put
                if (burst_open) begin
                    lfsr      = lfsr_step(lfsr);
                    beat_addr = {burst_addr[63:5], beat_idx[1:0], 3'b000};
                    r_valid <= lfsr[0];
                    r_data  <= {mem_word(beat_addr | 64'd4), mem_word(beat_addr)};
                    r_resp  <= (burst_err && beat_idx == 3'd2) ? 2'b10 : 2'b00;  // one bad beat
                    r_last  <= (beat_idx == 3'd3);
                end else begin
                    r_valid <= 1'b0;
                end
            end
        end
    end

    task automatic check_row(input row_t row, input int edges, input bit busy_seen,
                             input bit busy_gap, input int new_ars);
        expect_eq("fetch_err_o", 64'(fetch_err), 64'(row.err), flag_errs);
        if (!row.err) begin
            expect_eq("fetch_data_o", 64'(fetch_data),
                      64'(mem_word({row.addr[63:2], 2'b00})), data_errs);
        end
        expect_eq("axi_ar_valid_o handshakes", 64'(new_ars), 64'(row.new_ar), ar_errs);
        expect_eq("fetch_busy_o", 64'(fetch_busy), 64'd0, flag_errs);   // low in RESPOND
        if (row.new_ar) begin
            expect_eq("rlast to fetch_ready_o cycles", 64'(cycle - last_beat_cycle), 64'd2,
                      timing_errs);
            assert (busy_seen && !busy_gap) else begin
                $display("fetch_busy_o not held from miss to response, row %0d", row_idx);
                flag_errs++;
            end
        end else begin
            expect_eq("hit edges to fetch_ready_o", 64'(edges), 64'(HIT_EDGES), timing_errs);
            assert (!busy_seen) else begin
                $display("fetch_busy_o went high on a hit, row %0d", row_idx);
                flag_errs++;
            end
        end
    endtask

    task automatic report_counts();
        $display("errors: data %0d, ar %0d, timing %0d, flags %0d, bus %0d",
                 data_errs, ar_errs, timing_errs, flag_errs, bus_errs);
    endtask

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, row %0d never got fetch_ready_o", cycle, row_idx);
        report_counts();
        $display("Checks failed");
        $finish;
    end

    initial begin
        int ar_before;
        int edges;
        bit busy_seen;
        bit busy_gap;

        repeat (8) @(posedge clock);
        reset <= 1'b1;
        repeat (4) begin   // quiet bus before the first request
            @(negedge clock);
            assert (!ar_valid && !r_ready && !fetch_ready && !fetch_busy) else begin
                $display("DUT outputs active after reset with no request at %0t", $time);
                flag_errs++;
            end
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            row_idx   = i;
            cur_addr  = rows[i].addr;
            cur_err   = rows[i].err;
            ar_before = ar_count;
            edges     = 0;
            busy_seen = 1'b0;
            busy_gap  = 1'b0;
            @(posedge clock);
            fetch_valid <= 1'b1;
            fetch_addr  <= rows[i].addr;
            do begin
                @(negedge clock);
                edges++;
                if (fetch_busy) begin
                    busy_seen = 1'b1;
                end else if (busy_seen && !fetch_ready) begin
                    busy_gap = 1'b1;   // dropped before the response
                end
            end while (!fetch_ready);
            check_row(rows[i], edges, busy_seen, busy_gap, ar_count - ar_before);
            @(posedge clock);
            fetch_valid <= 1'b0;
        end
        report_counts();
        if (data_errs + ar_errs + timing_errs + flag_errs + bus_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
axi_pkg.sv
fetch_pkg.sv
axi_rd_if.sv
chan_slice.sv
fetch_ctrl.sv
beat_collector.sv
line_buffer.sv
ifetch_axi_top.sv
tb_ifetch.sv
